/* sim.f */
verilog/port_pkg.sv
verilog/port_router.sv
verilog/cfg_write_port.sv
verilog/cfg_read_port.sv
verilog/mem_arbiter.sv
verilog/cfg_mem.sv
verilog/port_hub_top.sv
tests/port_hub_chk.sv
tests/port_hub_tb.sv

/* Makefile */
# Verilator flow for the port hub

VERILATOR ?= verilator
TOP       ?= port_hub_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tests/port_hub_tb.sv */
// Port hub directed testbench
`default_nettype none
`timescale 1ns/10ps

module port_hub_tb;

	typedef logic [port_pkg::DATA_W-1:0] byte_t;
	typedef byte_t byte_q_t [$];

	// Block lengths and start addresses
	localparam int LEN_A = 16;
	localparam int LEN_WRAP = 6;
	localparam int LEN_B = 12;
	localparam byte_t ADDR_A = 8'h10;
	localparam byte_t ADDR_WRAP = 8'hfd;
	localparam byte_t ADDR_B = 8'h80;
	// Port served by no peer
	localparam logic [port_pkg::PORT_W-1:0] PORT_IDLE = 4'd2;

	// Bytes moved over all tests, frames plus replies
	localparam int TEST_BYTES = 8 * (LEN_A + 2) + 3 * (LEN_WRAP + 2) + 2 * (LEN_B + 2) + 1;
	localparam int WATCH_CYCLES = TEST_BYTES * 20 + 200;

	logic                        clk;
	logic                        rst;
	byte_t                       out_data;
	logic                        out_sof;
	logic                        out_eof;
	logic                        out_src_rdy;
	logic                        out_dst_rdy;
	logic [port_pkg::PORT_W-1:0] outport;
	byte_t                       in_data;
	logic                        in_sof;
	logic                        in_eof;
	logic                        in_src_rdy;
	logic                        in_dst_rdy;
	logic [port_pkg::PORT_W-1:0] inport;

	// Stimulus LFSR state
	logic [31:0] lfsr_q;
	// Expected memory contents
	byte_t model_mem [port_pkg::MEM_DEPTH];

	port_hub_top uut (
		.clk(clk),
		.rst(rst),
		.out_data(out_data),
		.out_sof(out_sof),
		.out_eof(out_eof),
		.out_src_rdy(out_src_rdy),
		.out_dst_rdy(out_dst_rdy),
		.outport(outport),
		.in_data(in_data),
		.in_sof(in_sof),
		.in_eof(in_eof),
		.in_src_rdy(in_src_rdy),
		.in_dst_rdy(in_dst_rdy),
		.inport(inport)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// Stimulus helpers
	// --------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic byte_q_t make_data(input int n);
		byte_q_t     q;
		logic [31:0] r;
		int          i;
		for (i = 0; i < n; i++) begin
			r = rand_bits(8);
			q.push_back(r[7:0]);
		end
		return q;
	endfunction

	// L+1 bytes from the model, address wraps at 256
	function automatic byte_q_t expected_reply(input byte_t addr, input byte_t len);
		byte_q_t q;
		byte_t   a;
		int      i;
		int      n;
		a = addr;
		n = int'(len);
		for (i = 0; i <= n; i++) begin
			q.push_back(model_mem[a]);
			a = a + 8'd1;
		end
		return q;
	endfunction

	// --------------------
	// Compare tasks
	// --------------------

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "data compare failed");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "flag compare failed");
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "count compare failed");
		end
	endtask

	// --------------------
	// Stream tasks
	// --------------------

	// One frame on the outgoing stream, counts cycles without dst_rdy
	task automatic send_frame(input logic [port_pkg::PORT_W-1:0] port, input byte_q_t bytes,
		output int stalls);
		int i;
		i = 0;
		stalls = 0;
		@(posedge clk);
		outport <= port;
		while (i < bytes.size()) begin
			out_data <= bytes[i];
			out_sof <= (i == 0);
			out_eof <= (i == bytes.size() - 1);
			out_src_rdy <= 1'b1;
			// Handshake settles between edges
			@(negedge clk);
			if (out_dst_rdy) begin
				i++;
			end else begin
				stalls++;
			end
			@(posedge clk);
		end
		out_src_rdy <= 1'b0;
		out_sof <= 1'b0;
		out_eof <= 1'b0;
	endtask

	// Collect a reply up to eof, dst_rdy from the LFSR when stalling
	task automatic recv_frame(input byte_q_t exp, input logic stall);
		int          count;
		logic        done;
		logic        last_eof;
		logic [31:0] r;
		count = 0;
		done = 1'b0;
		last_eof = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (stall) begin
				r = rand_bits(1);
				in_dst_rdy <= r[0];
			end else begin
				in_dst_rdy <= 1'b1;
			end
			@(negedge clk);
			if (in_src_rdy && in_dst_rdy) begin
				check_byte(in_data, exp[count], $sformatf("reply byte %0d", count));
				check_flag(in_sof, count == 0, $sformatf("sof on byte %0d", count));
				last_eof = in_eof;
				count++;
				// Ends on eof, or once the expected length has moved
				done = in_eof || (count == exp.size());
			end
		end
		check_count(count, exp.size(), "reply length");
		check_flag(last_eof, 1'b1, "eof on the last byte");
		@(posedge clk);
		in_dst_rdy <= 1'b0;
	endtask

	task automatic write_block(input byte_t addr, input byte_q_t data);
		byte_q_t frame;
		byte_t   a;
		int      stalls;
		frame = data;
		frame.push_front(addr);
		send_frame(port_pkg::PORT_CFG_WR, frame, stalls);
		a = addr;
		foreach (data[i]) begin
			model_mem[a] = data[i];
			a = a + 8'd1;
		end
	endtask

	task automatic start_read(input byte_t addr, input byte_t len);
		byte_q_t cmd;
		int      stalls;
		cmd.push_back(addr);
		cmd.push_back(len);
		send_frame(port_pkg::PORT_CFG_RD, cmd, stalls);
	endtask

	task automatic read_block(input byte_t addr, input byte_t len, input logic stall);
		byte_q_t exp;
		exp = expected_reply(addr, len);
		start_read(addr, len);
		recv_frame(exp, stall);
	endtask

	// Unserved inport gives a one-byte zero frame
	task automatic check_idle_reply(input logic [port_pkg::PORT_W-1:0] port);
		@(posedge clk);
		inport <= port;
		@(negedge clk);
		check_flag(in_src_rdy, 1'b1, "idle src_rdy");
		check_flag(in_sof, 1'b1, "idle sof");
		check_flag(in_eof, 1'b1, "idle eof");
		check_byte(in_data, 8'h00, "idle data");
		@(posedge clk);
		inport <= port_pkg::PORT_CFG_RD;
	endtask

	// --------------------
	// Tests
	// --------------------

	task automatic test_write_read();
		write_block(ADDR_A, make_data(LEN_A));
		read_block(ADDR_A, byte_t'(LEN_A - 1), 1'b0);
	endtask

	task automatic test_wrap();
		// Crosses 0xff into 0x00
		write_block(ADDR_WRAP, make_data(LEN_WRAP));
		read_block(ADDR_WRAP, byte_t'(LEN_WRAP - 1), 1'b0);
	endtask

	task automatic test_backpressure();
		read_block(ADDR_A, byte_t'(LEN_A - 1), 1'b1);
		read_block(ADDR_WRAP, byte_t'(LEN_WRAP - 1), 1'b1);
	endtask

	task automatic test_contention();
		byte_q_t exp_a;
		byte_q_t data_b;
		exp_a = expected_reply(ADDR_A, byte_t'(LEN_A - 1));
		data_b = make_data(LEN_B);
		start_read(ADDR_A, byte_t'(LEN_A - 1));
		// Reply and write share the memory port
		fork
			recv_frame(exp_a, 1'b0);
			write_block(ADDR_B, data_b);
		join
		read_block(ADDR_A, byte_t'(LEN_A - 1), 1'b0);
		read_block(ADDR_B, byte_t'(LEN_B - 1), 1'b0);
	endtask

	task automatic test_idle_ports();
		byte_q_t frame;
		int      stalls;
		check_idle_reply(4'd0);
		check_idle_reply(4'd1);
		@(posedge clk);
		outport <= PORT_IDLE;
		@(negedge clk);
		check_flag(out_dst_rdy, 1'b1, "idle out_dst_rdy");
		// Looks like a write frame, must be drained
		frame = make_data(LEN_A);
		frame.push_front(ADDR_A);
		send_frame(PORT_IDLE, frame, stalls);
		check_count(stalls, 0, "stall cycles on idle port");
		read_block(ADDR_A, byte_t'(LEN_A - 1), 1'b0);
	endtask

	task automatic test_single_byte();
		byte_q_t frame;
		int      stalls;
		// Address byte with eof, nothing to write
		frame.push_back(ADDR_A);
		send_frame(port_pkg::PORT_CFG_WR, frame, stalls);
		read_block(ADDR_A, byte_t'(LEN_A - 1), 1'b0);
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		lfsr_q = 32'he7d2_fb08;
		rst = 1'b1;
		out_data = '0;
		out_sof = 1'b0;
		out_eof = 1'b0;
		out_src_rdy = 1'b0;
		outport = '0;
		in_dst_rdy = 1'b0;
		inport = port_pkg::PORT_CFG_RD;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_write_read();
		test_wrap();
		test_backpressure();
		test_contention();
		test_idle_ports();
		test_single_byte();
		repeat (4) @(posedge clk);
		if (uut.chk.fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times", uut.chk.fail_cnt);
			$display("*** TEST FAILED ***");
			$fatal(1, "protocol assertions failed");
		end
	end

	// Protocol assertion failures end the run right away
	always @(posedge clk) begin
		if (uut.chk.fail_cnt != 0) begin
			$display("Protocol assertion failed at %0t", $time);
			$display("*** TEST FAILED ***");
			$fatal(1, "protocol assertion failed");
		end
	end

	// Watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("Run did not finish within %0d cycles", WATCH_CYCLES);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* tests/port_hub_chk.sv */
// Port hub protocol checks
`default_nettype none
`timescale 1ns/10ps

module port_hub_chk (
	input logic                        clk,
	input logic                        rst,
	// Arbiter
	input logic                        wr_req,
	input logic                        wr_gnt,
	input logic                        rd_req,
	input logic                        rd_gnt,
	// Return stream
	input logic [port_pkg::PORT_W-1:0] inport,
	input logic                        in_src_rdy,
	input logic                        in_dst_rdy,
	input logic [port_pkg::DATA_W-1:0] in_data,
	input logic                        in_sof,
	input logic                        in_eof
);

	// Failed assertions, read by the testbench at the end
	int fail_cnt = 0;

	// --------------------
	// Arbiter
	// --------------------

	a_one_grant: assert property (@(posedge clk) disable iff (rst) !(wr_gnt && rd_gnt))
	else begin
		$error("write and read grants both high");
		fail_cnt++;
	end

	a_wr_gnt_req: assert property (@(posedge clk) disable iff (rst) wr_gnt |-> wr_req)
	else begin
		$error("write grant without request");
		fail_cnt++;
	end

	a_rd_gnt_req: assert property (@(posedge clk) disable iff (rst) rd_gnt |-> rd_req)
	else begin
		$error("read grant without request");
		fail_cnt++;
	end

	// --------------------
	// Return stream
	// --------------------

	// Stalled reply byte holds on port 4
	a_reply_hold: assert property (@(posedge clk) disable iff (rst)
		(inport == port_pkg::PORT_CFG_RD && in_src_rdy && !in_dst_rdy) |=>
		(in_src_rdy && $stable(in_data) && $stable(in_sof) && $stable(in_eof)))
	else begin
		$error("reply byte changed while stalled");
		fail_cnt++;
	end

endmodule

bind port_hub_top port_hub_chk chk (
	.clk(clk),
	.rst(rst),
	.wr_req(wr_req),
	.wr_gnt(wr_gnt),
	.rd_req(rd_req),
	.rd_gnt(rd_gnt),
	.inport(inport),
	.in_src_rdy(in_src_rdy),
	.in_dst_rdy(in_dst_rdy),
	.in_data(in_data),
	.in_sof(in_sof),
	.in_eof(in_eof)
);

`default_nettype wire

/* verilog/port_hub_top.sv */
// Port hub top level
`default_nettype none
`timescale 1ns/10ps

module port_hub_top (
	input  logic                        clk,
	input  logic                        rst,
	// Outgoing stream from the host
	input  logic [port_pkg::DATA_W-1:0] out_data,
	input  logic                        out_sof,
	input  logic                        out_eof,
	input  logic                        out_src_rdy,
	output logic                        out_dst_rdy,
	input  logic [port_pkg::PORT_W-1:0] outport,
	// Return stream to the host
	output logic [port_pkg::DATA_W-1:0] in_data,
	output logic                        in_sof,
	output logic                        in_eof,
	output logic                        in_src_rdy,
	input  logic                        in_dst_rdy,
	input  logic [port_pkg::PORT_W-1:0] inport
);

	// Selects and peer readiness
	logic wr_sel;
	logic rd_sel;
	logic wr_dst_rdy;
	logic rd_dst_rdy;

	// Reply stream from the read port
	logic                        rd_reply;
	logic                        rd_src_rdy;
	logic [port_pkg::DATA_W-1:0] rd_data;
	logic                        rd_sof;
	logic                        rd_eof;

	// Arbiter requests
	logic                        wr_req;
	logic                        wr_gnt;
	logic [port_pkg::MEM_AW-1:0] wr_addr;
	logic [port_pkg::DATA_W-1:0] wr_data;
	logic                        rd_req;
	logic                        rd_gnt;
	logic [port_pkg::MEM_AW-1:0] rd_addr;

	// Memory port
	logic                        mem_we;
	logic [port_pkg::MEM_AW-1:0] mem_addr;
	logic [port_pkg::DATA_W-1:0] mem_wdata;
	logic [port_pkg::DATA_W-1:0] mem_rdata;

	port_router u_router (
		.outport(outport),
		.inport(inport),
		.out_src_rdy(out_src_rdy),
		.out_dst_rdy(out_dst_rdy),
		.wr_sel(wr_sel),
		.rd_sel(rd_sel),
		.wr_dst_rdy(wr_dst_rdy),
		.rd_dst_rdy(rd_dst_rdy),
		.rd_reply(rd_reply),
		.rd_src_rdy(rd_src_rdy),
		.rd_data(rd_data),
		.rd_sof(rd_sof),
		.rd_eof(rd_eof),
		.in_src_rdy(in_src_rdy),
		.in_data(in_data),
		.in_sof(in_sof),
		.in_eof(in_eof)
	);

	cfg_write_port u_wr (
		.clk(clk),
		.rst(rst),
		.sel(wr_sel),
		.data(out_data),
		.sof(out_sof),
		.eof(out_eof),
		.src_rdy(out_src_rdy),
		.dst_rdy(wr_dst_rdy),
		.req(wr_req),
		.addr(wr_addr),
		.wdata(wr_data),
		.gnt(wr_gnt)
	);

	cfg_read_port u_rd (
		.clk(clk),
		.rst(rst),
		.sel(rd_sel),
		.data(out_data),
		.sof(out_sof),
		.eof(out_eof),
		.src_rdy(out_src_rdy),
		.dst_rdy(rd_dst_rdy),
		.req(rd_req),
		.addr(rd_addr),
		.gnt(rd_gnt),
		.rdata(mem_rdata),
		.reply(rd_reply),
		.out_src_rdy(rd_src_rdy),
		.out_data(rd_data),
		.out_sof(rd_sof),
		.out_eof(rd_eof),
		.out_dst_rdy(in_dst_rdy)
	);

	mem_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_gnt(wr_gnt),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_gnt(rd_gnt),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	cfg_mem u_mem (
		.clk(clk),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

/* verilog/cfg_mem.sv */
// Configuration memory
`default_nettype none
`timescale 1ns/10ps

module cfg_mem (
	input  logic                        clk,
	input  logic                        we,
	input  logic [port_pkg::MEM_AW-1:0] addr,
	input  logic [port_pkg::DATA_W-1:0] wdata,
	output logic [port_pkg::DATA_W-1:0] rdata
);

	logic [port_pkg::DATA_W-1:0] ram [port_pkg::MEM_DEPTH];

	// Registered read, old data on a write cycle
	always_ff @(posedge clk) begin
		if (we) begin
			ram[addr] <= wdata;
		end
		rdata <= ram[addr];
	end

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
// Round-robin memory arbiter
`default_nettype none
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                        clk,
	input  logic                        rst,
	// Write port request
	input  logic                        wr_req,
	input  logic [port_pkg::MEM_AW-1:0] wr_addr,
	input  logic [port_pkg::DATA_W-1:0] wr_data,
	output logic                        wr_gnt,
	// Read port request
	input  logic                        rd_req,
	input  logic [port_pkg::MEM_AW-1:0] rd_addr,
	output logic                        rd_gnt,
	// Single memory port
	output logic                        mem_we,
	output logic [port_pkg::MEM_AW-1:0] mem_addr,
	output logic [port_pkg::DATA_W-1:0] mem_wdata
);

	// Winner of the last granted cycle
	port_pkg::mem_owner_t last_q;
	port_pkg::mem_owner_t win;

	// Tie goes to the loser of the last grant
	always_comb begin
		win = port_pkg::OWN_NONE;
		if (wr_req && rd_req) begin
			win = (last_q == port_pkg::OWN_WR) ? port_pkg::OWN_RD : port_pkg::OWN_WR;
		end else if (wr_req) begin
			win = port_pkg::OWN_WR;
		end else if (rd_req) begin
			win = port_pkg::OWN_RD;
		end
	end

	assign wr_gnt = (win == port_pkg::OWN_WR);
	assign rd_gnt = (win == port_pkg::OWN_RD);

	// Memory port mux
	assign mem_we = wr_gnt;
	assign mem_addr = rd_gnt ? rd_addr : wr_addr;
	assign mem_wdata = wr_data;

	// Write port wins the first tie
	always_ff @(posedge clk) begin
		if (rst) begin
			last_q <= port_pkg::OWN_RD;
		end else if (win != port_pkg::OWN_NONE) begin
			last_q <= win;
		end
	end

endmodule

`default_nettype wire

/* verilog/cfg_read_port.sv */
// Configuration read port
`default_nettype none
`timescale 1ns/10ps

module cfg_read_port (
	input  logic                        clk,
	input  logic                        rst,
	// Outgoing stream, port 4 commands
	input  logic                        sel,
	input  logic [port_pkg::DATA_W-1:0] data,
	input  logic                        sof,
	input  logic                        eof,
	input  logic                        src_rdy,
	output logic                        dst_rdy,
	// Memory request side
	output logic                        req,
	output logic [port_pkg::MEM_AW-1:0] addr,
	input  logic                        gnt,
	input  logic [port_pkg::DATA_W-1:0] rdata,
	// Return stream
	input  logic                        reply,
	output logic                        out_src_rdy,
	output logic [port_pkg::DATA_W-1:0] out_data,
	output logic                        out_sof,
	output logic                        out_eof,
	input  logic                        out_dst_rdy
);

	port_pkg::rd_state_t state;

	// Read pointer, reads left to issue, bytes left to send
	logic [port_pkg::MEM_AW-1:0] rd_ptr;
	logic [port_pkg::MEM_AW:0]   iss_cnt;
	logic [port_pkg::MEM_AW:0]   snd_cnt;
	logic                        first_q;

	// Two-entry reply buffer
	logic [port_pkg::DATA_W-1:0] buf_mem [2];
	logic                        wr_idx;
	logic                        rd_idx;
	logic [1:0]                  buf_cnt;
	// Read granted last cycle, rdata valid now
	logic                        pend;

	logic take;
	logic addr_load;
	logic len_load;
	logic space;
	logic pop;

	// --------------------
	// Command side
	// --------------------

	// Commands stall from the length byte to the reply eof
	assign dst_rdy = (state == port_pkg::RD_ADDR) | (state == port_pkg::RD_LEN);
	assign take = sel & src_rdy & dst_rdy;

	// Only sof bytes start a command, tail bytes fall through
	assign addr_load = take & sof;
	assign len_load = take & ~sof & (state == port_pkg::RD_LEN);

	// --------------------
	// Memory side
	// --------------------

	// Room for one more byte counting the one in flight
	assign space = (buf_cnt == 2'd0) | ((buf_cnt == 2'd1) & ~pend);
	assign req = (state == port_pkg::RD_SEND) & (iss_cnt != '0) & space;
	assign addr = rd_ptr;

	// Return stream from the buffer head
	assign out_src_rdy = reply & (buf_cnt != 2'd0);
	assign out_data = buf_mem[rd_idx];
	assign out_sof = first_q;
	assign out_eof = (snd_cnt == 1);
	assign pop = out_src_rdy & out_dst_rdy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= port_pkg::RD_ADDR;
			iss_cnt <= '0;
			snd_cnt <= '0;
			first_q <= 1'b0;
			pend <= 1'b0;
		end else begin
			pend <= gnt;
			case (state)
				port_pkg::RD_ADDR: begin
					if (addr_load && !eof) begin
						state <= port_pkg::RD_LEN;
					end
				end
				port_pkg::RD_LEN: begin
					// Fresh sof with eof is a cut command
					if (len_load) begin
						state <= port_pkg::RD_SEND;
					end else if (addr_load && eof) begin
						state <= port_pkg::RD_ADDR;
					end
				end
				port_pkg::RD_SEND: begin
					if (gnt && iss_cnt == 1) begin
						state <= port_pkg::RD_LAST;
					end
				end
				default: begin
					// Wait for the reply eof to move
					if (pop && out_eof) begin
						state <= port_pkg::RD_ADDR;
					end
				end
			endcase
			// Reply is L+1 bytes
			if (len_load) begin
				iss_cnt <= {1'b0, data} + 1'b1;
				snd_cnt <= {1'b0, data} + 1'b1;
				first_q <= 1'b1;
			end else begin
				if (gnt) begin
					iss_cnt <= iss_cnt - 1'b1;
				end
				if (pop) begin
					snd_cnt <= snd_cnt - 1'b1;
					first_q <= 1'b0;
				end
			end
		end
	end

	// Read pointer
	always_ff @(posedge clk) begin
		if (addr_load) begin
			rd_ptr <= data;
		end else if (gnt) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// --------------------
	// Buffer
	// --------------------

	always_ff @(posedge clk) begin
		if (pend) begin
			buf_mem[wr_idx] <= rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_idx <= 1'b0;
			rd_idx <= 1'b0;
			buf_cnt <= 2'd0;
		end else begin
			if (pend) begin
				wr_idx <= ~wr_idx;
			end
			if (pop) begin
				rd_idx <= ~rd_idx;
			end
			case ({pend, pop})
				2'b10: buf_cnt <= buf_cnt + 1'b1;
				2'b01: buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/cfg_write_port.sv */
// Configuration write port
`default_nettype none
`timescale 1ns/10ps

module cfg_write_port (
	input  logic                        clk,
	input  logic                        rst,
	// Outgoing stream, port 3
	input  logic                        sel,
	input  logic [port_pkg::DATA_W-1:0] data,
	input  logic                        sof,
	input  logic                        eof,
	input  logic                        src_rdy,
	output logic                        dst_rdy,
	// Memory request side
	output logic                        req,
	output logic [port_pkg::MEM_AW-1:0] addr,
	output logic [port_pkg::DATA_W-1:0] wdata,
	input  logic                        gnt
);

	port_pkg::wr_state_t state;

	// Next write address
	logic [port_pkg::MEM_AW-1:0] addr_q;

	logic is_addr;
	logic take;

	// --------------------
	// Handshake
	// --------------------

	// First byte of a frame is the address
	// A stray sof restarts the frame
	assign is_addr = (state == port_pkg::WR_ADDR) | sof;

	// Address byte is always taken
	// Data bytes wait for the memory
	assign dst_rdy = is_addr ? 1'b1 : gnt;

	// Byte moves on this edge
	assign take = sel & src_rdy & dst_rdy;

	// Data byte on offer needs a memory cycle
	assign req = sel & src_rdy & ~is_addr;
	assign addr = addr_q;
	assign wdata = data;

	// --------------------
	// Frame state
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= port_pkg::WR_ADDR;
		end else if (take) begin
			// eof ends the frame, even on the address byte
			if (eof) begin
				state <= port_pkg::WR_ADDR;
			end else if (is_addr) begin
				state <= port_pkg::WR_DATA;
			end
		end
	end

	// Address counter
	always_ff @(posedge clk) begin
		if (take) begin
			if (is_addr) begin
				addr_q <= data;
			end else begin
				// Wraps at the top of memory
				addr_q <= addr_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/port_router.sv */
// Port decode and return mux
`default_nettype none
`timescale 1ns/10ps

module port_router (
	// Port numbers from the host
	input  logic [port_pkg::PORT_W-1:0] outport,
	input  logic [port_pkg::PORT_W-1:0] inport,
	// Outgoing stream handshake
	input  logic                        out_src_rdy,
	output logic                        out_dst_rdy,
	// Peer selects
	output logic                        wr_sel,
	output logic                        rd_sel,
	// Peer readiness
	input  logic                        wr_dst_rdy,
	input  logic                        rd_dst_rdy,
	// Return stream from the read port
	output logic                        rd_reply,
	input  logic                        rd_src_rdy,
	input  logic [port_pkg::DATA_W-1:0] rd_data,
	input  logic                        rd_sof,
	input  logic                        rd_eof,
	// Return stream to the host
	output logic                        in_src_rdy,
	output logic [port_pkg::DATA_W-1:0] in_data,
	output logic                        in_sof,
	output logic                        in_eof
);

	logic peer_sel;
	logic peer_rdy;

	// --------------------
	// Outgoing side
	// --------------------

	// Selects follow the port number only
	assign wr_sel = (outport == port_pkg::PORT_CFG_WR);
	assign rd_sel = (outport == port_pkg::PORT_CFG_RD);
	assign peer_sel = wr_sel | rd_sel;

	// Readiness of whichever peer owns the port
	assign peer_rdy = wr_sel ? wr_dst_rdy : rd_dst_rdy;

	// Peers answer only while a byte is offered
	// Any other port is drained
	assign out_dst_rdy = peer_sel ? (peer_rdy & out_src_rdy) : 1'b1;

	// --------------------
	// Return side
	// --------------------

	assign rd_reply = (inport == port_pkg::PORT_CFG_RD);

	// Unserved ports give a one-byte frame of zero
	assign in_src_rdy = rd_reply ? rd_src_rdy : 1'b1;
	assign in_data = rd_reply ? rd_data : '0;
	assign in_sof = rd_reply ? rd_sof : 1'b1;
	assign in_eof = rd_reply ? rd_eof : 1'b1;

endmodule

`default_nettype wire

/* verilog/port_pkg.sv */
// Port hub shared definitions
`default_nettype none

package port_pkg;

	// --------------------
	// Stream and port widths
	// --------------------

	// Width of outport and inport
	localparam int PORT_W = 4;
	// Stream and memory byte width
	localparam int DATA_W = 8;

	// Host port numbers served by the peers
	localparam logic [PORT_W-1:0] PORT_CFG_WR = 4'd3;
	localparam logic [PORT_W-1:0] PORT_CFG_RD = 4'd4;

	// --------------------
	// Configuration memory
	// --------------------

	// Address width, addresses wrap at the top
	localparam int MEM_AW = 8;
	// Number of bytes held
	localparam int MEM_DEPTH = 1 << MEM_AW;

	// --------------------
	// State and owner types
	// --------------------

	// Write port: address byte, then data bytes
	typedef enum logic {
		WR_ADDR,
		WR_DATA
	} wr_state_t;

	// Read port: command bytes, then reply
	typedef enum logic [1:0] {
		RD_ADDR,
		RD_LEN,
		RD_SEND,
		RD_LAST
	} rd_state_t;

	// Memory port owner for one cycle
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_WR,
		OWN_RD
	} mem_owner_t;

endpackage

`default_nettype wire
